/* hw/c16_mem_consts.svh */
/*
 * Shared constants for the C16/Plus/4 memory block.
 * Widths, download indexes, ROM slot numbers and the fixed CPU
 * addresses used by the router, the decoder and the fabric.
 * Include wherever one of these values is needed.
 */
`ifndef C16_MEM_CONSTS_SVH
`define C16_MEM_CONSTS_SVH

// Bus and memory widths
`define C16_ADDR_W      16
`define C16_DATA_W      8
`define ROM_ADDR_W      14
`define DL_ADDR_W       25
`define DL_SLOT_W       11

// Download stream indexes
`define DL_IDX_SYS      8'd0
`define DL_IDX_PRG      8'd1
`define DL_IDX_CART     8'd2

// 16 KB slots inside a system ROM image
`define SLOT_KERNAL     11'd1
`define SLOT_BASIC      11'd2
`define SLOT_FUNC_LO    11'd3
`define SLOT_FUNC_HI    11'd4

// 16 KB slots inside a cartridge image
`define SLOT_CART_LO    11'd0
`define SLOT_CART_HI    11'd1

// CPU addresses with a fixed meaning
`define ADDR_ROM_ON     16'hFF3E
`define ADDR_RAM_ON     16'hFF3F
`define PAGE_BANK_SEL   12'hFDD
`define PAGE_KERNAL_FIX 8'hFC
`define IO_LO           16'hFD00
`define IO_HI           16'hFF3F

// BASIC pointer low bytes, high byte sits at the next address
`define PTR_PATCH_0     16'h002D
`define PTR_PATCH_1     16'h002F
`define PTR_PATCH_2     16'h0031
`define PTR_PATCH_3     16'h009D

`endif

/* hw/c16_mem_pkg.sv */
/*
 * Types shared by the C16/Plus/4 memory block.
 * Download beats, Wishbone requests, RAM and ROM write strobes and
 * the memory map classification all travel as the structs below.
 */
`include "c16_mem_consts.svh"

package c16_mem_pkg;

	////////////////////////////////////////////////////////////
	// Memory sources seen from the CPU bus
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		SRC_RAM,
		SRC_KERNAL,
		SRC_BASIC,
		SRC_FUNC_LO,
		SRC_FUNC_HI,
		SRC_CART_LO,
		SRC_CART_HI,
		SRC_OPEN
	} mem_src_e;

	// One download address, as a byte count or as slot plus offset
	typedef union packed {
		logic [`DL_ADDR_W-1:0] flat;
		struct packed {
			logic [`DL_SLOT_W-1:0]  slot;
			logic [`ROM_ADDR_W-1:0] offset;
		} split;
	} dl_addr_u;

	typedef struct packed {
		logic                   active;  // High for the whole transfer
		logic                   wr;      // Byte strobe
		logic [7:0]             index;
		dl_addr_u               addr;
		logic [`C16_DATA_W-1:0] data;
	} dl_beat_t;

	////////////////////////////////////////////////////////////
	// CPU side and internal write strobes
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`C16_ADDR_W-1:0] adr;
		logic [`C16_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                   we;
		logic [`C16_ADDR_W-1:0] addr;
		logic [`C16_DATA_W-1:0] data;
	} ram_wr_t;

	typedef struct packed {
		logic                   we;
		mem_src_e               slot;
		logic [`ROM_ADDR_W-1:0] offset;
		logic [`C16_DATA_W-1:0] data;
	} rom_wr_t;

	typedef struct packed {
		mem_src_e src;
		logic     io;      // Address lies in FD00..FF3F
	} map_sel_t;

endpackage

/* hw/download_router.sv */
/*
 * Download port of the memory block.
 * Program files go to main RAM from the load address held in their
 * first two bytes. When the transfer ends the end address is written
 * into the BASIC pointers. ROM and cart images go to their slots.
 */
`include "c16_mem_consts.svh"
`timescale 1ns/1ps

module download_router (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  c16_mem_pkg::dl_beat_t dl_i,
	output c16_mem_pkg::ram_wr_t  ram_wr_o,
	output c16_mem_pkg::rom_wr_t  rom_wr_o
);
	import c16_mem_pkg::*;

	logic                   beat;
	logic                   prg_beat;
	logic                   hdr_byte;
	logic                   prg_q;
	logic                   prg_end;
	logic [3:0]             patch_q;
	logic [`C16_ADDR_W-1:0] load_addr_q;
	logic [`C16_ADDR_W-1:0] patch_base;
	logic                   rom_hit;
	mem_src_e               rom_src;

	logic                   ram_we_q;
	logic [`C16_ADDR_W-1:0] ram_addr_q;
	logic [`C16_DATA_W-1:0] ram_data_q;
	logic                   rom_we_q;
	mem_src_e               rom_slot_q;
	logic [`ROM_ADDR_W-1:0] rom_off_q;
	logic [`C16_DATA_W-1:0] rom_data_q;

	assign beat     = dl_i.active && dl_i.wr;
	assign prg_beat = beat && (dl_i.index == `DL_IDX_PRG);
	// Bytes 0 and 1 carry the load address
	assign hdr_byte = (dl_i.addr.flat[`DL_ADDR_W-1:1] == '0);
	assign prg_end  = prg_q && !dl_i.active;

	// Pointer pair for the running patch step
	always_comb begin
		case (patch_q[3:2])
			2'd0:    patch_base = `PTR_PATCH_0;
			2'd1:    patch_base = `PTR_PATCH_1;
			2'd2:    patch_base = `PTR_PATCH_2;
			default: patch_base = `PTR_PATCH_3;
		endcase
	end

	// ROM slot lookup from the slot view of the address
	always_comb begin
		rom_hit = beat;
		rom_src = SRC_OPEN;
		if (dl_i.index == `DL_IDX_SYS) begin
			case (dl_i.addr.split.slot)
				`SLOT_KERNAL:  rom_src = SRC_KERNAL;
				`SLOT_BASIC:   rom_src = SRC_BASIC;
				`SLOT_FUNC_LO: rom_src = SRC_FUNC_LO;
				`SLOT_FUNC_HI: rom_src = SRC_FUNC_HI;
				default:       rom_hit = 1'b0;
			endcase
		end else if (dl_i.index == `DL_IDX_CART) begin
			case (dl_i.addr.split.slot)
				`SLOT_CART_LO: rom_src = SRC_CART_LO;
				`SLOT_CART_HI: rom_src = SRC_CART_HI;
				default:       rom_hit = 1'b0;
			endcase
		end else begin
			rom_hit = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Control state and the patch sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			prg_q    <= 1'b0;
			patch_q  <= 4'd0;
			ram_we_q <= 1'b0;
			rom_we_q <= 1'b0;
		end else begin
			prg_q    <= dl_i.active && (dl_i.index == `DL_IDX_PRG);
			ram_we_q <= (prg_beat && !hdr_byte) || patch_q[0];
			rom_we_q <= rom_hit;
			// Odd steps write, so one byte every second cycle
			if (prg_end) begin
				patch_q <= 4'd1;
			end else if (patch_q != 4'd0) begin
				patch_q <= patch_q + 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_beat) begin
			if (dl_i.addr.flat == `DL_ADDR_W'd0) begin
				load_addr_q[7:0] <= dl_i.data;
			end else if (dl_i.addr.flat == `DL_ADDR_W'd1) begin
				load_addr_q[15:8] <= dl_i.data;
			end else begin
				load_addr_q <= load_addr_q + 1'b1;
			end
		end
		if (patch_q[0]) begin
			ram_addr_q <= patch_base + {{(`C16_ADDR_W-1){1'b0}}, patch_q[1]};
			ram_data_q <= patch_q[1] ? load_addr_q[15:8] : load_addr_q[7:0];
		end else begin
			ram_addr_q <= load_addr_q;
			ram_data_q <= dl_i.data;
		end
		rom_slot_q <= rom_src;
		rom_off_q  <= dl_i.addr.split.offset;
		rom_data_q <= dl_i.data;
	end

	assign ram_wr_o = '{we: ram_we_q, addr: ram_addr_q, data: ram_data_q};
	assign rom_wr_o = '{we: rom_we_q, slot: rom_slot_q, offset: rom_off_q, data: rom_data_q};

endmodule

/* hw/bank_decoder.sv */
/*
 * CPU memory map of the C16/Plus/4.
 * Keeps the ROM enable and the Plus/4 bank latch, both set by bus
 * writes, and classifies the current bus address into a source.
 */
`include "c16_mem_consts.svh"
`timescale 1ns/1ps

module bank_decoder (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  model_i,
	input  c16_mem_pkg::wb_req_t  wb_i,
	output c16_mem_pkg::map_sel_t map_o
);
	import c16_mem_pkg::*;

	logic       model_q;    // 1 for Plus/4
	logic       rom_on_q;
	logic [1:0] bank_lo_q;
	logic [1:0] bank_hi_q;
	logic       wr_req;
	logic       in_io;
	mem_src_e   src;

	assign wr_req = wb_i.cyc && wb_i.stb && wb_i.we;

	////////////////////////////////////////////////////////////
	// Latches written from the bus
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q   <= model_i;
			rom_on_q  <= 1'b1;
			bank_lo_q <= 2'd0;
			bank_hi_q <= 2'd0;
		end else if (wr_req) begin
			if (wb_i.adr == `ADDR_ROM_ON) begin
				rom_on_q <= 1'b1;
			end
			if (wb_i.adr == `ADDR_RAM_ON) begin
				rom_on_q <= 1'b0;
			end
			// Bank number comes from the low address nibble
			if (model_q && (wb_i.adr[15:4] == `PAGE_BANK_SEL)) begin
				bank_hi_q <= wb_i.adr[3:2];
				bank_lo_q <= wb_i.adr[1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Address classification
	////////////////////////////////////////////////////////////
	assign in_io = (wb_i.adr >= `IO_LO) && (wb_i.adr <= `IO_HI);

	always_comb begin
		src = SRC_RAM;
		if (!wb_i.adr[15] || !rom_on_q) begin
			src = SRC_RAM;
		end else if (!wb_i.adr[14]) begin
			// 8000..BFFF
			case (bank_lo_q)
				2'd0:    src = SRC_BASIC;
				2'd1:    src = SRC_CART_LO;
				2'd2:    src = SRC_FUNC_LO;
				default: src = SRC_OPEN;
			endcase
		end else if (wb_i.adr[15:8] == `PAGE_KERNAL_FIX) begin
			src = SRC_KERNAL;
		end else begin
			case (bank_hi_q)
				2'd0:    src = SRC_KERNAL;
				2'd1:    src = SRC_CART_HI;
				2'd2:    src = SRC_FUNC_HI;
				default: src = SRC_OPEN;
			endcase
		end
	end

	assign map_o = '{src: src, io: in_io};

endmodule

/* hw/mem_fabric.sv */
/*
 * Storage and Wishbone slave of the memory block.
 * Holds the 64 KB main RAM and the six 16 KB ROM slots, takes the
 * download writes and answers CPU cycles one clock after the request
 * with the data of the source picked by the bank decoder.
 */
`include "c16_mem_consts.svh"
`timescale 1ns/1ps

module mem_fabric (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  c16_mem_pkg::ram_wr_t   ram_wr_i,
	input  c16_mem_pkg::rom_wr_t   rom_wr_i,
	input  c16_mem_pkg::wb_req_t   wb_i,
	input  c16_mem_pkg::map_sel_t  map_i,
	output logic [`C16_DATA_W-1:0] wb_dat_o,
	output logic                   wb_ack_o
);
	import c16_mem_pkg::*;

	logic [`C16_DATA_W-1:0] ram_mem [0:(1 << `C16_ADDR_W)-1];
	// Kernal, BASIC, function low/high, cart low/high
	logic [`C16_DATA_W-1:0] rom_mem [0:5][0:(1 << `ROM_ADDR_W)-1];

	logic                   ack_q;
	logic                   bus_req;
	logic                   bus_wr;
	logic [`C16_DATA_W-1:0] ram_q;
	logic [`C16_DATA_W-1:0] rom_q;
	mem_src_e               src_q;
	logic                   io_q;
	logic                   cart_lo_q;
	logic                   cart_hi_q;

	function automatic logic [2:0] rom_index(input mem_src_e src);
		case (src)
			SRC_BASIC:   return 3'd1;
			SRC_FUNC_LO: return 3'd2;
			SRC_FUNC_HI: return 3'd3;
			SRC_CART_LO: return 3'd4;
			SRC_CART_HI: return 3'd5;
			default:     return 3'd0;
		endcase
	endfunction

	// Unprogrammed ROM reads as erased
	initial begin
		for (int s = 0; s < 6; s++) begin
			for (int a = 0; a < (1 << `ROM_ADDR_W); a++) begin
				rom_mem[s][a] = 8'hFF;
			end
		end
	end

	assign bus_req = wb_i.cyc && wb_i.stb && !ack_q;
	assign bus_wr  = bus_req && wb_i.we && !map_i.io;

	////////////////////////////////////////////////////////////
	// Handshake and cart presence
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q     <= 1'b0;
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
		end else begin
			ack_q <= bus_req;
			if (rom_wr_i.we && (rom_wr_i.slot == SRC_CART_LO)) begin
				cart_lo_q <= 1'b1;
			end
			if (rom_wr_i.we && (rom_wr_i.slot == SRC_CART_HI)) begin
				cart_hi_q <= 1'b1;
			end
		end
	end

	// Port A from the router, port B from the CPU bus
	always_ff @(posedge clk_sys) begin
		if (ram_wr_i.we) begin
			ram_mem[ram_wr_i.addr] <= ram_wr_i.data;
		end
		if (bus_wr) begin
			ram_mem[wb_i.adr] <= wb_i.dat;
		end
		ram_q <= ram_mem[wb_i.adr];
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr_i.we) begin
			rom_mem[rom_index(rom_wr_i.slot)][rom_wr_i.offset] <= rom_wr_i.data;
		end
		rom_q <= rom_mem[rom_index(map_i.src)][wb_i.adr[`ROM_ADDR_W-1:0]];
		src_q <= map_i.src;
		io_q  <= map_i.io;
	end

	////////////////////////////////////////////////////////////
	// Read data select
	////////////////////////////////////////////////////////////
	always_comb begin
		if (io_q) begin
			wb_dat_o = 8'hFF;
		end else begin
			case (src_q)
				SRC_RAM:     wb_dat_o = ram_q;
				SRC_OPEN:    wb_dat_o = 8'hFF;
				SRC_CART_LO: wb_dat_o = cart_lo_q ? rom_q : 8'hFF;
				SRC_CART_HI: wb_dat_o = cart_hi_q ? rom_q : 8'hFF;
				default:     wb_dat_o = rom_q;
			endcase
		end
	end

	assign wb_ack_o = ack_q;

endmodule

/* hw/c16_mem_top.sv */
/*
 * Top of the C16/Plus/4 memory block.
 * The download router and the bank decoder run side by side and
 * the memory fabric combines their outputs into the Wishbone answer.
 */
`include "c16_mem_consts.svh"
`timescale 1ns/1ps

module c16_mem_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_i,
	input  c16_mem_pkg::dl_beat_t  dl_i,
	input  c16_mem_pkg::wb_req_t   wb_i,
	output logic [`C16_DATA_W-1:0] wb_dat_o,
	output logic                   wb_ack_o
);

	c16_mem_pkg::ram_wr_t  ram_wr;
	c16_mem_pkg::rom_wr_t  rom_wr;
	c16_mem_pkg::map_sel_t map_sel;

	////////////////////////////////////////////////////////////
	// Download side
	////////////////////////////////////////////////////////////
	download_router download_router_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_i     (dl_i),
		.ram_wr_o (ram_wr),
		.rom_wr_o (rom_wr)
	);

	// CPU memory map
	bank_decoder bank_decoder_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model_i (model_i),
		.wb_i    (wb_i),
		.map_o   (map_sel)
	);

	////////////////////////////////////////////////////////////
	// RAM, ROM slots and bus answer
	////////////////////////////////////////////////////////////
	mem_fabric mem_fabric_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ram_wr_i (ram_wr),
		.rom_wr_i (rom_wr),
		.wb_i     (wb_i),
		.map_i    (map_sel),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o)
	);

endmodule

/* verif/clock_gen.sv */
/*
 * Free-running clk_sys source for the memory block testbench.
 * 100 ns period, starts low at time zero.
 */
`timescale 1ns/1ps

module clock_gen (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	// Half period of 50 ns
	always #50 clk_o = ~clk_o;

endmodule

/* verif/c16_mem_tb.sv */
/*
 * Testbench for the C16/Plus/4 memory block.
 * Reads the command trace, drives downloads and Wishbone cycles into
 * the DUT on the falling clock edge and checks every bus read against
 * the value given in the trace. One line per test, then a count line.
 */
`timescale 1ns/1ps

module c16_mem_tb;
	import c16_mem_pkg::*;

	logic           clk_sys;
	logic           reset;
	logic           model_i;
	dl_beat_t       dl;
	wb_req_t        wb;
	logic [7:0]     wb_dat_o;
	logic           wb_ack_o;

	int             fd;
	int             limit;
	int             cycles;
	int             errors;
	int             checks;
	int             tests;
	logic           model_sel;

	clock_gen clock_gen_i (
		.clk_o (clk_sys)
	);

	c16_mem_top dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.model_i  (model_i),
		.dl_i     (dl),
		.wb_i     (wb),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o)
	);

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////
	// Model is taken by the DUT while reset is high
	task automatic apply_reset();
		@(negedge clk_sys);
		model_i = model_sel;
		reset   = 1'b1;
		dl      = '0;
		wb      = '0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic send_beat(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		@(negedge clk_sys);
		dl.active    = 1'b1;
		dl.wr        = 1'b1;
		dl.index     = index;
		dl.addr.flat = addr;
		dl.data      = data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	// Patch sequence needs up to 18 cycles after active falls
	task automatic end_download();
		@(negedge clk_sys);
		dl.active = 1'b0;
		dl.wr     = 1'b0;
		repeat (20) @(negedge clk_sys);
	endtask

	task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] dat,
			output logic [7:0] rdata, output logic acked);
		int wait_n;
		@(negedge clk_sys);
		wb.cyc = 1'b1;
		wb.stb = 1'b1;
		wb.we  = we;
		wb.adr = adr;
		wb.dat = dat;
		acked  = 1'b0;
		rdata  = 8'h00;
		wait_n = 0;
		while (!acked && wait_n < 4) begin
			@(negedge clk_sys);
			wait_n++;
			if (wb_ack_o) begin
				acked = 1'b1;
				rdata = wb_dat_o;
			end
		end
		wb.cyc = 1'b0;
		wb.stb = 1'b0;
		wb.we  = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] adr, input logic [7:0] dat);
		logic [7:0] unused_rd;
		logic       acked;
		bus_cycle(1'b1, adr, dat, unused_rd, acked);
		checks++;
		if (!acked) begin
			$display("No ack within 4 cycles for the write to %h at %0t ns", adr, $time);
			errors++;
		end
	endtask

	task automatic bus_read(input logic [15:0] adr, input logic [7:0] expected);
		logic [7:0] got;
		logic       acked;
		bus_cycle(1'b0, adr, 8'h00, got, acked);
		checks++;
		if (!acked) begin
			$display("No ack within 4 cycles for the read of %h at %0t ns", adr, $time);
			errors++;
		end else if (got !== expected) begin
			$display("Fail at %0t ns: wb_dat_o for %h expected %h got %h",
				$time, adr, expected, got);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Trace runner
	////////////////////////////////////////////////////////////
	task automatic run_trace();
		logic [8*32-1:0]  cmd;
		logic [8*32-1:0]  name;
		logic [8*128-1:0] rest;
		logic [31:0]      a0;
		logic [31:0]      a1;
		logic [31:0]      a2;
		int               n;
		int               base_err;
		int               base_chk;
		name     = '0;
		base_err = 0;
		base_chk = 0;
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				n = $fgets(rest, fd);
			end else if (cmd == "model") begin
				n = $fscanf(fd, "%d", a0);
				model_sel = a0[0];
			end else if (cmd == "test") begin
				n = $fscanf(fd, "%s", name);
				tests++;
				base_err = errors;
				base_chk = checks;
				apply_reset();
			end else if (cmd == "dl") begin
				n = $fscanf(fd, "%h %h %h", a0, a1, a2);
				send_beat(a0[7:0], a1[24:0], a2[7:0]);
			end else if (cmd == "dl_end") begin
				end_download();
			end else if (cmd == "wr") begin
				n = $fscanf(fd, "%h %h", a0, a1);
				bus_write(a0[15:0], a1[7:0]);
			end else if (cmd == "rd") begin
				n = $fscanf(fd, "%h %h", a0, a1);
				bus_read(a0[15:0], a1[7:0]);
			end else if (cmd == "end") begin
				$display("%0s: %0d checks, %0d errors", name,
					checks - base_chk, errors - base_err);
			end else begin
				$display("Unknown command %0s in the trace", cmd);
				errors++;
			end
		end
	endtask

	initial begin : main
		logic [8*128-1:0] line;
		int               lines;
		reset     = 1'b1;
		model_i   = 1'b0;
		model_sel = 1'b0;
		dl        = '0;
		wb        = '0;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		lines     = 0;
		fd = $fopen("verif/c16_mem_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file verif/c16_mem_trace.txt");
			errors++;
		end else begin
			// Count lines first to size the timeout
			while ($fgets(line, fd) != 0) begin
				lines++;
			end
			$fclose(fd);
			limit = lines * 40 + 200;
			fd = $fopen("verif/c16_mem_trace.txt", "r");
			run_trace();
			$fclose(fd);
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Run limit from the trace length
	initial begin : watchdog
		cycles = 0;
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

endmodule

/* verif/c16_mem_trace.txt */
# Columns: command then arguments, numbers in hex except the model (0 C16, 1 Plus/4)
# model m | test name | dl index addr data | dl_end | wr adr dat | rd adr expected | end
model 1
test rom_images
dl 0 8000 B0
dl 0 8005 B5
dl 0 A000 B2
dl 0 4000 C0
dl 0 7C00 FC
dl 0 C000 F1
dl 0 10000 F2
dl_end
rd 8000 B0
rd 8005 B5
rd C000 C0
rd FC00 FC
wr FDD5 00
rd 8000 FF
rd C000 FF
rd FC00 FC
end
model 0
test ram_under_rom
wr A000 5A
rd A000 B2
wr FF3F 00
rd A000 5A
wr FF3E 00
rd A000 B2
end
test program_load
dl 1 0 01
dl 1 1 10
dl 1 2 11
dl 1 3 22
dl 1 4 33
dl 1 5 44
dl 1 6 55
dl_end
rd 1001 11
rd 1002 22
rd 1003 33
rd 1004 44
rd 1005 55
rd 002D 06
rd 002E 10
rd 002F 06
rd 0030 10
rd 0031 06
rd 0032 10
rd 009D 06
rd 009E 10
end
model 1
test plus4_banking
dl 2 0 A1
dl 2 1 A2
dl 2 4000 D1
dl_end
wr FDD5 00
rd 8000 A1
rd 8001 A2
rd C000 D1
rd 8010 FF
wr FDDA 00
rd 8000 F1
rd C000 F2
end
model 0
test c16_io
wr FDD5 00
rd 8000 B0
rd C000 C0
rd FD00 FF
rd FF3E FF
wr A000 C3
wr FE00 77
wr FF3F 00
rd A000 C3
rd FE00 FF
end

/* c16_mem.f */
+incdir+hw
hw/c16_mem_pkg.sv
hw/download_router.sv
hw/bank_decoder.sv
hw/mem_fabric.sv
hw/c16_mem_top.sv
verif/clock_gen.sv
verif/c16_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory block testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module c16_mem_tb \
	-f c16_mem.f \
	-o Vc16_mem_tb

./obj_dir/Vc16_mem_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
